// File: flist.f
hdl/memShimPkg.sv
hdl/reqFifo.sv
hdl/pageTable.sv
hdl/tlbShim.sv
hdl/memShimTop.sv
testbench/memShimTb.sv

// File: hdl/memShimPkg.sv
package memShimPkg;

    // ========================================================================
    // Sizing
    // ========================================================================

    // A virtual line address is a page number on top of a page offset
    localparam int VAddrBits  = 16;
    localparam int PAddrBits  = 20;
    localparam int OffsetBits = 12;
    localparam int VpnBits    = 4;
    localparam int PpnBits    = 8;

    localparam int TagBits  = 8;
    localparam int DataBits = 64;

    // Request buffering on the AFU side
    localparam int ReqFifoDepth = 8;
    // Almost full rises once free slots drop to this many or fewer
    localparam int AlmFullSlack = 2;

    // Derived widths for the FIFO pointers and occupancy count
    localparam int FifoPtrBits = $clog2(ReqFifoDepth);
    localparam int FifoCntBits = $clog2(ReqFifoDepth + 1);

    // One page table entry per virtual page
    localparam int PtEntries = 2 ** VpnBits;

    // ========================================================================
    // Plain vector types
    // ========================================================================

    typedef logic [VAddrBits-1:0] vAddrT;
    typedef logic [PAddrBits-1:0] pAddrT;
    typedef logic [VpnBits-1:0]   vpnT;
    typedef logic [PpnBits-1:0]   ppnT;
    typedef logic [TagBits-1:0]   tagT;
    typedef logic [DataBits-1:0]  dataT;

    // ========================================================================
    // Structs
    // ========================================================================

    // Page table entry, an invalid entry means the page is unmapped
    typedef struct packed {
        logic valid;
        ppnT  ppn;
    } pteT;

    // AFU side requests carry virtual addresses
    typedef struct packed {
        tagT   tag;
        vAddrT vAddr;
    } afuRdReqT;

    typedef struct packed {
        tagT   tag;
        vAddrT vAddr;
        dataT  data;
    } afuWrReqT;

    // Platform side requests carry physical addresses
    typedef struct packed {
        tagT   tag;
        pAddrT pAddr;
    } memRdReqT;

    typedef struct packed {
        tagT   tag;
        pAddrT pAddr;
        dataT  data;
    } memWrReqT;

    // Responses are the same on both sides of the shim
    typedef struct packed {
        tagT  tag;
        dataT data;
    } rdRspT;

    typedef struct packed {
        tagT tag;
    } wrRspT;

    // Report for a request that hit an unmapped page
    typedef struct packed {
        tagT   tag;
        vAddrT vAddr;
        logic  isWrite;
    } faultT;

endpackage

// File: hdl/memShimTop.sv
module memShimTop (
    input  logic                  clk,
    input  logic                  reset,
    // Page table configuration
    input  logic                  ptWrValid,
    input  memShimPkg::vpnT       ptWrVpn,
    input  memShimPkg::pteT       ptWrEntry,
    // AFU request channels
    input  logic                  afuRdValid,
    input  memShimPkg::afuRdReqT  afuRdReq,
    output logic                  afuRdAlmFull,
    input  logic                  afuWrValid,
    input  memShimPkg::afuWrReqT  afuWrReq,
    output logic                  afuWrAlmFull,
    // Platform request channels
    input  logic                  memAlmFull,
    output logic                  memRdValid,
    output memShimPkg::memRdReqT  memRdReq,
    output logic                  memWrValid,
    output memShimPkg::memWrReqT  memWrReq,
    // Unmapped page report
    output logic                  faultValid,
    output memShimPkg::faultT     fault,
    // Response channels
    input  logic                  memRdRspValid,
    input  memShimPkg::rdRspT     memRdRsp,
    input  logic                  memWrRspValid,
    input  memShimPkg::wrRspT     memWrRsp,
    output logic                  afuRdRspValid,
    output memShimPkg::rdRspT     afuRdRsp,
    output logic                  afuWrRspValid,
    output memShimPkg::wrRspT     afuWrRsp
);
    import memShimPkg::*;

    // FIFO heads and the dequeue pulses that retire them
    logic     rdNotEmpty;
    afuRdReqT rdFirst;
    logic     rdDeq;
    logic     wrNotEmpty;
    afuWrReqT wrFirst;
    logic     wrDeq;

    // Page table lookups, one per channel
    vpnT rdVpn;
    pteT rdPte;
    vpnT wrVpn;
    pteT wrPte;

    // ========================================================================
    // Request buffers
    // ========================================================================

    // Buffering makes the AFU side insensitive to platform latency
    reqFifo #(.entryT(afuRdReqT)) u_rdFifo (
        .clk,
        .reset,
        .enqValid   (afuRdValid),
        .enqData    (afuRdReq),
        .almostFull (afuRdAlmFull),
        .deq        (rdDeq),
        .notEmpty   (rdNotEmpty),
        .first      (rdFirst)
    );

    reqFifo #(.entryT(afuWrReqT)) u_wrFifo (
        .clk,
        .reset,
        .enqValid   (afuWrValid),
        .enqData    (afuWrReq),
        .almostFull (afuWrAlmFull),
        .deq        (wrDeq),
        .notEmpty   (wrNotEmpty),
        .first      (wrFirst)
    );

    // ========================================================================
    // Translation
    // ========================================================================

    pageTable u_pageTable (
        .clk,
        .reset,
        .wrValid  (ptWrValid),
        .wrVpn    (ptWrVpn),
        .wrEntry  (ptWrEntry),
        .rdVpnA   (rdVpn),
        .rdEntryA (rdPte),
        .rdVpnB   (wrVpn),
        .rdEntryB (wrPte)
    );

    tlbShim u_tlbShim (
        .clk,
        .reset,
        .rdNotEmpty,
        .rdFirst,
        .rdDeq,
        .wrNotEmpty,
        .wrFirst,
        .wrDeq,
        .rdVpn,
        .rdPte,
        .wrVpn,
        .wrPte,
        .memAlmFull,
        .memRdValid,
        .memRdReq,
        .memWrValid,
        .memWrReq,
        .faultValid,
        .fault,
        .memRdRspValid,
        .memRdRsp,
        .memWrRspValid,
        .memWrRsp,
        .afuRdRspValid,
        .afuRdRsp,
        .afuWrRspValid,
        .afuWrRsp
    );

endmodule

// File: hdl/pageTable.sv
module pageTable (
    input  logic             clk,
    input  logic             reset,
    // Configuration write port, driven by software
    input  logic             wrValid,
    input  memShimPkg::vpnT  wrVpn,
    input  memShimPkg::pteT  wrEntry,
    // Lookup port for the read channel
    input  memShimPkg::vpnT  rdVpnA,
    output memShimPkg::pteT  rdEntryA,
    // Lookup port for the write channel
    input  memShimPkg::vpnT  rdVpnB,
    output memShimPkg::pteT  rdEntryB
);
    import memShimPkg::*;

    // ========================================================================
    // Entry storage
    // ========================================================================

    // One entry per virtual page, indexed directly by the page number
    pteT entries [PtEntries];

    // Every page starts unmapped, so stray requests after reset fault
    // instead of reaching some arbitrary physical page
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PtEntries; i++) begin
                entries[i] <= '0;
            end
        end else if (wrValid) begin
            // The new mapping is seen by lookups from the next cycle on
            entries[wrVpn] <= wrEntry;
        end
    end

    // ========================================================================
    // Lookup
    // ========================================================================

    // Both channels translate in the same cycle, hence two read ports
    // with no arbitration between them
    assign rdEntryA = entries[rdVpnA];
    assign rdEntryB = entries[rdVpnB];

endmodule

// File: hdl/reqFifo.sv
module reqFifo #(
    parameter type entryT = logic
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  enqValid,
    input  entryT enqData,
    output logic  almostFull,
    input  logic  deq,
    output logic  notEmpty,
    output entryT first
);
    import memShimPkg::*;

    // Storage is a plain circular buffer, the head is read combinationally
    entryT                  buffer [ReqFifoDepth];
    logic [FifoPtrBits-1:0] wrPtr;
    logic [FifoPtrBits-1:0] rdPtr;
    logic [FifoCntBits-1:0] count;
    logic [FifoCntBits-1:0] countNext;

    // Pointer advance with wrap at the buffer depth
    function automatic logic [FifoPtrBits-1:0] ptrInc(input logic [FifoPtrBits-1:0] ptr);
        return (ptr == FifoPtrBits'(ReqFifoDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Occupancy after this cycle's enqueue and dequeue
    always_comb begin
        unique case ({enqValid, deq})
            2'b10:   countNext = count + 1'b1;
            2'b01:   countNext = count - 1'b1;
            default: countNext = count;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            notEmpty   <= 1'b0;
            almostFull <= 1'b0;
        end else begin
            if (enqValid) begin
                wrPtr <= ptrInc(wrPtr);
            end
            if (deq) begin
                rdPtr <= ptrInc(rdPtr);
            end
            count    <= countNext;
            notEmpty <= (countNext != '0);
            // Free slots at or below the slack, so the AFU gets a cycle of warning
            almostFull <= (countNext >= FifoCntBits'(ReqFifoDepth - AlmFullSlack));
        end
    end

    // An entry written at one edge is at the head right after it
    always_ff @(posedge clk) begin
        if (enqValid) begin
            buffer[wrPtr] <= enqData;
        end
    end

    assign first = buffer[rdPtr];

    // The AFU must have honoured almostFull, so a full buffer never sees a push
    // unless the head leaves in the same cycle
    enqNotFull: assert property (@(posedge clk) disable iff (reset)
        enqValid |-> (count != FifoCntBits'(ReqFifoDepth)) || deq)
        else $error("reqFifo: enqueue while full");

    // The shim may only pop what it saw at the head
    deqNotEmpty: assert property (@(posedge clk) disable iff (reset)
        deq |-> notEmpty)
        else $error("reqFifo: dequeue while empty");

endmodule

// File: hdl/tlbShim.sv
module tlbShim (
    input  logic                  clk,
    input  logic                  reset,
    // Read request FIFO head
    input  logic                  rdNotEmpty,
    input  memShimPkg::afuRdReqT  rdFirst,
    output logic                  rdDeq,
    // Write request FIFO head
    input  logic                  wrNotEmpty,
    input  memShimPkg::afuWrReqT  wrFirst,
    output logic                  wrDeq,
    // Page table lookups
    output memShimPkg::vpnT       rdVpn,
    input  memShimPkg::pteT       rdPte,
    output memShimPkg::vpnT       wrVpn,
    input  memShimPkg::pteT       wrPte,
    // Platform request side
    input  logic                  memAlmFull,
    output logic                  memRdValid,
    output memShimPkg::memRdReqT  memRdReq,
    output logic                  memWrValid,
    output memShimPkg::memWrReqT  memWrReq,
    // Fault report
    output logic                  faultValid,
    output memShimPkg::faultT     fault,
    // Responses from the platform
    input  logic                  memRdRspValid,
    input  memShimPkg::rdRspT     memRdRsp,
    input  logic                  memWrRspValid,
    input  memShimPkg::wrRspT     memWrRsp,
    // Responses toward the AFU
    output logic                  afuRdRspValid,
    output memShimPkg::rdRspT     afuRdRsp,
    output logic                  afuWrRspValid,
    output memShimPkg::wrRspT     afuWrRsp
);
    import memShimPkg::*;

    logic [OffsetBits-1:0] rdOffset;
    logic [OffsetBits-1:0] wrOffset;
    logic                  rdGo;
    logic                  wrGo;
    logic                  rdFault;
    logic                  wrFault;

    // ========================================================================
    // Translation
    // ========================================================================

    // Page number is the top of the line address, the offset passes through
    assign rdVpn    = rdFirst.vAddr[VAddrBits-1 -: VpnBits];
    assign wrVpn    = wrFirst.vAddr[VAddrBits-1 -: VpnBits];
    assign rdOffset = rdFirst.vAddr[OffsetBits-1:0];
    assign wrOffset = wrFirst.vAddr[OffsetBits-1:0];

    // A head entry is acted on only while the platform can take more
    assign rdGo = rdNotEmpty && !memAlmFull;
    assign wrGo = wrNotEmpty && !memAlmFull;

    // Unmapped pages go to the fault port, reads win a shared cycle and
    // the faulting write stays at its head for one more cycle
    assign rdFault = rdGo && !rdPte.valid;
    assign wrFault = wrGo && !wrPte.valid && !rdFault;

    assign memRdValid = rdGo && rdPte.valid;
    assign memWrValid = wrGo && wrPte.valid;

    // Either outcome retires the head entry
    assign rdDeq = memRdValid || rdFault;
    assign wrDeq = memWrValid || wrFault;

    always_comb begin
        memRdReq.tag   = rdFirst.tag;
        memRdReq.pAddr = {rdPte.ppn, rdOffset};
        memWrReq.tag   = wrFirst.tag;
        memWrReq.pAddr = {wrPte.ppn, wrOffset};
        memWrReq.data  = wrFirst.data;
    end

    // ========================================================================
    // Fault reporting
    // ========================================================================

    assign faultValid = rdFault || wrFault;

    always_comb begin
        if (rdFault) begin
            fault.tag     = rdFirst.tag;
            fault.vAddr   = rdFirst.vAddr;
            fault.isWrite = 1'b0;
        end else begin
            fault.tag     = wrFirst.tag;
            fault.vAddr   = wrFirst.vAddr;
            fault.isWrite = 1'b1;
        end
    end

    // ========================================================================
    // Responses
    // ========================================================================

    // Responses need no translation, they go straight back to the AFU
    assign afuRdRspValid = memRdRspValid;
    assign afuRdRsp      = memRdRsp;
    assign afuWrRspValid = memWrRspValid;
    assign afuWrRsp      = memWrRsp;

    // A read held back by the platform or the arbitration stays at the head
    // until it is retired, so nothing is lost and order is kept
    rdHeadHolds: assert property (@(posedge clk) disable iff (reset)
        (rdNotEmpty && !rdDeq) |=> (rdNotEmpty && $stable(rdFirst)))
        else $error("tlbShim: read head changed without a dequeue");

    // The same holds for a write that waits behind a read fault
    wrHeadHolds: assert property (@(posedge clk) disable iff (reset)
        (wrNotEmpty && !wrDeq) |=> (wrNotEmpty && $stable(wrFirst)))
        else $error("tlbShim: write head changed without a dequeue");

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module memShimTb -f flist.f -o simv

# The simulator exits non-zero on a fatal error, the search below decides
out=$(./obj_dir/simv 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "No errors"; then
    exit 0
else
    exit 1
fi

// File: testbench/memShimTb.sv
module memShimTb;
    import memShimPkg::*;

    localparam int ClkHalf       = 20;
    localparam int ResetCycles   = 10;
    localparam int TimeoutCycles = 2000;

    logic     clk;
    logic     reset;
    logic     ptWrValid;
    vpnT      ptWrVpn;
    pteT      ptWrEntry;
    logic     afuRdValid;
    afuRdReqT afuRdReq;
    logic     afuRdAlmFull;
    logic     afuWrValid;
    afuWrReqT afuWrReq;
    logic     afuWrAlmFull;
    logic     memAlmFull;
    logic     memRdValid;
    memRdReqT memRdReq;
    logic     memWrValid;
    memWrReqT memWrReq;
    logic     faultValid;
    faultT    fault;
    logic     memRdRspValid;
    rdRspT    memRdRsp;
    logic     memWrRspValid;
    wrRspT    memWrRsp;
    logic     afuRdRspValid;
    rdRspT    afuRdRsp;
    logic     afuWrRspValid;
    wrRspT    afuWrRsp;

    // Reference page table and the outcomes still owed by the DUT
    pteT      tbPt [PtEntries];
    memRdReqT expRd [$];
    memWrReqT expWr [$];
    faultT    expFault [$];
    string    curTest;
    int       cycles;

    memShimTop u_memShimTop (.*);

    initial begin
        clk = 1'b0;
        forever #ClkHalf clk = ~clk;
    end

    // ========================================================================
    // Failure reporting and compare tasks
    // ========================================================================

    task automatic abortRun();
        $display("Errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic failWith(input string msg);
        $display("%s: %s", curTest, msg);
        abortRun();
    endtask

    task automatic checkRdReq(input memRdReqT exp, input memRdReqT act);
        if (act !== exp) begin
            $display("ERR %s memRdReq expected %h actual %h", curTest, exp, act);
            abortRun();
        end
    endtask

    task automatic checkWrReq(input memWrReqT exp, input memWrReqT act);
        if (act !== exp) begin
            $display("ERR %s memWrReq expected %h actual %h", curTest, exp, act);
            abortRun();
        end
    endtask

    task automatic checkFault(input faultT exp, input faultT act);
        if (act !== exp) begin
            $display("ERR %s fault expected %h actual %h", curTest, exp, act);
            abortRun();
        end
    endtask

    task automatic checkRdRsp(input rdRspT exp, input rdRspT act);
        if (act !== exp) begin
            $display("ERR %s afuRdRsp expected %h actual %h", curTest, exp, act);
            abortRun();
        end
    endtask

    task automatic checkWrRsp(input wrRspT exp, input wrRspT act);
        if (act !== exp) begin
            $display("ERR %s afuWrRsp expected %h actual %h", curTest, exp, act);
            abortRun();
        end
    endtask

    // Hard stop in case the DUT stops draining
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TimeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
            abortRun();
        end
    end

    // Outputs are combinational from the head, so sample them mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            // Nothing is checked while the DUT is held in reset
        end else if (memAlmFull && (memRdValid || memWrValid)) begin
            failWith("memory request issued while memAlmFull was high");
        end else begin
            if (memRdValid) begin
                if (expRd.size() == 0) failWith("unexpected memory read request");
                else checkRdReq(expRd.pop_front(), memRdReq);
            end
            if (memWrValid) begin
                if (expWr.size() == 0) failWith("unexpected memory write request");
                else checkWrReq(expWr.pop_front(), memWrReq);
            end
            if (faultValid) begin
                if (expFault.size() == 0) failWith("unexpected fault report");
                else checkFault(expFault.pop_front(), fault);
            end
        end
    end

    // ========================================================================
    // Drivers, all called and returning just after a rising edge
    // ========================================================================

    task automatic mapPage(input vpnT vpn, input logic valid, input ppnT ppn);
        pteT e;
        e.valid   = valid;
        e.ppn     = ppn;
        tbPt[vpn] = e;
        ptWrValid = 1'b1;
        ptWrVpn   = vpn;
        ptWrEntry = e;
        @(posedge clk);
        #2;
        ptWrValid = 1'b0;
    endtask

    // Predicts either a translated read or a read fault from the table copy
    task automatic sendRead(input vpnT vpn);
        pteT      pte;
        memRdReqT m;
        faultT    f;
        while (afuRdAlmFull) begin
            @(posedge clk);
            #2;
        end
        afuRdReq.tag   = tagT'($urandom);
        afuRdReq.vAddr = {vpn, OffsetBits'($urandom)};
        pte = tbPt[vpn];
        if (pte.valid) begin
            m.tag   = afuRdReq.tag;
            m.pAddr = {pte.ppn, afuRdReq.vAddr[OffsetBits-1:0]};
            expRd.push_back(m);
        end else begin
            f.tag     = afuRdReq.tag;
            f.vAddr   = afuRdReq.vAddr;
            f.isWrite = 1'b0;
            expFault.push_back(f);
        end
        afuRdValid = 1'b1;
        @(posedge clk);
        #2;
        afuRdValid = 1'b0;
    endtask

    task automatic sendWrite(input vpnT vpn);
        pteT      pte;
        memWrReqT m;
        faultT    f;
        while (afuWrAlmFull) begin
            @(posedge clk);
            #2;
        end
        afuWrReq.tag   = tagT'($urandom);
        afuWrReq.vAddr = {vpn, OffsetBits'($urandom)};
        afuWrReq.data  = {$urandom, $urandom};
        pte = tbPt[vpn];
        if (pte.valid) begin
            m.tag   = afuWrReq.tag;
            m.pAddr = {pte.ppn, afuWrReq.vAddr[OffsetBits-1:0]};
            // Write data must pass the shim untouched
            m.data  = afuWrReq.data;
            expWr.push_back(m);
        end else begin
            f.tag     = afuWrReq.tag;
            f.vAddr   = afuWrReq.vAddr;
            f.isWrite = 1'b1;
            expFault.push_back(f);
        end
        afuWrValid = 1'b1;
        @(posedge clk);
        #2;
        afuWrValid = 1'b0;
    endtask

    task automatic waitDrain();
        while (expRd.size() != 0 || expWr.size() != 0 || expFault.size() != 0) begin
            @(posedge clk);
            #2;
        end
        repeat (2) @(posedge clk);
        #2;
    endtask

    // ========================================================================
    // Tests
    // ========================================================================

    task automatic testReadTranslate();
        curTest = "testReadTranslate";
        mapPage(4'h1, 1'b1, 8'h23);
        mapPage(4'h2, 1'b1, 8'h7f);
        mapPage(4'h5, 1'b1, 8'hc1);
        for (int i = 0; i < 9; i++) sendRead(vpnT'(i % 3 == 0 ? 1 : (i % 3 == 1 ? 2 : 5)));
        waitDrain();
    endtask

    task automatic testWriteTranslate();
        curTest = "testWriteTranslate";
        for (int i = 0; i < 9; i++) sendWrite(vpnT'(i % 3 == 0 ? 5 : (i % 3 == 1 ? 1 : 2)));
        waitDrain();
    endtask

    // Page 3 was never mapped, so those requests must fault
    task automatic testUnmappedFault();
        curTest = "testUnmappedFault";
        sendRead(4'h1);
        sendRead(4'h3);
        sendRead(4'h2);
        sendRead(4'h3);
        sendWrite(4'h3);
        sendWrite(4'h5);
        sendWrite(4'h3);
        waitDrain();
    endtask

    task automatic testBackPressure();
        int rdSent;
        int wrSent;
        curTest = "testBackPressure";
        rdSent = 0;
        wrSent = 0;
        memAlmFull = 1'b1;
        while (!afuRdAlmFull) begin
            sendRead(vpnT'(rdSent % 2 == 0 ? 1 : 2));
            rdSent++;
        end
        while (!afuWrAlmFull) begin
            sendWrite(vpnT'(wrSent % 2 == 0 ? 2 : 5));
            wrSent++;
        end
        // Almost full rises once only AlmFullSlack slots remain free
        if (rdSent != ReqFifoDepth - AlmFullSlack || wrSent != ReqFifoDepth - AlmFullSlack)
            failWith("almost-full flag rose at the wrong fill level");
        repeat (5) @(posedge clk);
        #2;
        if (expRd.size() != rdSent || expWr.size() != wrSent)
            failWith("requests left the FIFOs while memAlmFull was high");
        memAlmFull = 1'b0;
        waitDrain();
    endtask

    task automatic testResponsePassthrough();
        rdRspT r;
        wrRspT w;
        curTest = "testResponsePassthrough";
        for (int i = 0; i < 8; i++) begin
            r.tag  = tagT'($urandom);
            r.data = {$urandom, $urandom};
            w.tag  = tagT'($urandom);
            memRdRspValid = 1'b1;
            memRdRsp      = r;
            memWrRspValid = 1'b1;
            memWrRsp      = w;
            @(negedge clk);
            if (!afuRdRspValid || !afuWrRspValid)
                failWith("response valid did not reach the AFU in the same cycle");
            checkRdRsp(r, afuRdRsp);
            checkWrRsp(w, afuWrRsp);
            @(posedge clk);
            #2;
        end
        memRdRspValid = 1'b0;
        memWrRspValid = 1'b0;
        @(negedge clk);
        if (afuRdRspValid || afuWrRspValid)
            failWith("response valid reached the AFU with no platform response");
        @(posedge clk);
        #2;
    endtask

    task automatic testRemap();
        curTest = "testRemap";
        mapPage(4'h2, 1'b1, 8'h44);
        mapPage(4'h5, 1'b0, 8'h00);
        sendRead(4'h2);
        sendRead(4'h5);
        sendWrite(4'h5);
        sendWrite(4'h2);
        waitDrain();
    endtask

    initial begin
        void'($urandom(7));
        cycles        = 0;
        curTest       = "reset";
        reset         = 1'b1;
        ptWrValid     = 1'b0;
        ptWrVpn       = '0;
        ptWrEntry     = '0;
        afuRdValid    = 1'b0;
        afuRdReq      = '0;
        afuWrValid    = 1'b0;
        afuWrReq      = '0;
        memAlmFull    = 1'b0;
        memRdRspValid = 1'b0;
        memRdRsp      = '0;
        memWrRspValid = 1'b0;
        memWrRsp      = '0;
        for (int i = 0; i < PtEntries; i++) tbPt[i] = '0;
        repeat (ResetCycles) @(posedge clk);
        #2;
        reset = 1'b0;
        testReadTranslate();
        testWriteTranslate();
        testUnmappedFault();
        testBackPressure();
        testResponsePassthrough();
        testRemap();
        $display("No errors");
        $finish;
    end

endmodule
